// File: hdl/tk1_pkg.sv
// tk1 security core shared definitions
// Address map, identification words, memory limits and the
// common types used by the register file, mode control and
// security monitor

`default_nettype none

package tk1_pkg;

  // --------------------
  // Types
  // --------------------
  typedef logic [31:0] word_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [2:0]  cdi_index_t;

  // Privilege state, firmware runs with full rights
  typedef enum logic {
    MODE_FIRMWARE = 1'b0,
    MODE_APP      = 1'b1
  } mode_state_t;

  // --------------------
  // Register addresses
  // --------------------
  localparam reg_addr_t ADDR_NAME0            = 8'h00;
  localparam reg_addr_t ADDR_NAME1            = 8'h01;
  localparam reg_addr_t ADDR_VERSION          = 8'h02;

  localparam reg_addr_t ADDR_SYSTEM_MODE_CTRL = 8'h08;

  localparam reg_addr_t ADDR_APP_START        = 8'h0c;
  localparam reg_addr_t ADDR_APP_SIZE         = 8'h0d;

  localparam reg_addr_t ADDR_BLAKE2S          = 8'h10;
  localparam reg_addr_t ADDR_SYSCALL          = 8'h12;

  localparam reg_addr_t ADDR_CDI_FIRST        = 8'h20;
  localparam reg_addr_t ADDR_CDI_LAST         = 8'h27;

  localparam reg_addr_t ADDR_CPU_MON_CTRL     = 8'h60;
  localparam reg_addr_t ADDR_CPU_MON_FIRST    = 8'h61;
  localparam reg_addr_t ADDR_CPU_MON_LAST     = 8'h62;

  // --------------------
  // Identification
  // --------------------
  localparam word_t TK1_NAME0   = 32'h746b3120;  // "tk1 "
  localparam word_t TK1_NAME1   = 32'h6d6b6466;  // "mkdf"
  localparam word_t TK1_VERSION = 32'h00000005;

  // --------------------
  // Memory map
  // --------------------
  localparam word_t FW_RAM_FIRST = 32'hd0000000;
  localparam word_t FW_RAM_LAST  = 32'hd00007ff;

  // ROM starts at address zero
  localparam word_t FW_ROM_LAST  = 32'h00001fff;

  // Outside physical memory, so an unset entry point traps when used
  localparam word_t ILLEGAL_ADDR = 32'h4f000000;

endpackage

`default_nettype wire

// File: hdl/tk1_reg_file.sv
// tk1 register file
// Decodes the single-cycle bus, holds the application and entry
// point registers, the CDI words and the execution monitor setup,
// and multiplexes read data

`default_nettype none

module tk1_reg_file (
  input  logic               clk,
  input  logic               reset_n,

  input  logic               cs,
  input  logic               we,
  input  tk1_pkg::reg_addr_t address,
  input  tk1_pkg::word_t     write_data,
  output tk1_pkg::word_t     read_data,
  output logic               ready,

  input  logic               system_mode,

  output tk1_pkg::word_t     syscall_addr,
  output tk1_pkg::word_t     blake2s_addr,
  output tk1_pkg::word_t     mon_first,
  output tk1_pkg::word_t     mon_last,
  output logic               mon_en
);

  tk1_pkg::word_t     app_start;
  tk1_pkg::word_t     app_size;
  tk1_pkg::word_t     cdi_mem [8];

  tk1_pkg::cdi_index_t cdi_index;
  logic                cdi_hit;

  logic bus_write;
  logic fw_write;
  logic app_start_we;
  logic app_size_we;
  logic blake2s_we;
  logic syscall_we;
  logic cdi_we;
  logic mon_en_we;
  logic mon_first_we;
  logic mon_last_we;

  // --------------------
  // Write decode
  // --------------------
  assign cdi_index = address[2:0];
  assign cdi_hit   = (address >= tk1_pkg::ADDR_CDI_FIRST) &&
                     (address <= tk1_pkg::ADDR_CDI_LAST);

  assign bus_write = cs && we;

  // Application code may not touch these
  assign fw_write     = bus_write && !system_mode;
  assign app_start_we = fw_write && (address == tk1_pkg::ADDR_APP_START);
  assign app_size_we  = fw_write && (address == tk1_pkg::ADDR_APP_SIZE);
  assign blake2s_we   = fw_write && (address == tk1_pkg::ADDR_BLAKE2S);
  assign syscall_we   = fw_write && (address == tk1_pkg::ADDR_SYSCALL);
  assign cdi_we       = fw_write && cdi_hit;

  // Window is frozen once the monitor is armed
  assign mon_en_we    = bus_write && (address == tk1_pkg::ADDR_CPU_MON_CTRL);
  assign mon_first_we = bus_write && !mon_en && (address == tk1_pkg::ADDR_CPU_MON_FIRST);
  assign mon_last_we  = bus_write && !mon_en && (address == tk1_pkg::ADDR_CPU_MON_LAST);

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_start    <= '0;
      app_size     <= '0;
      blake2s_addr <= tk1_pkg::ILLEGAL_ADDR;
      syscall_addr <= tk1_pkg::ILLEGAL_ADDR;
      mon_en       <= 1'b0;
      mon_first    <= '0;
      mon_last     <= '0;
      for (int i = 0; i < 8; i++) begin
        cdi_mem[i] <= '0;
      end
    end else begin
      if (app_start_we) begin
        app_start <= write_data;
      end
      if (app_size_we) begin
        app_size <= write_data;
      end
      if (blake2s_we) begin
        blake2s_addr <= write_data;
      end
      if (syscall_we) begin
        syscall_addr <= write_data;
      end
      if (cdi_we) begin
        cdi_mem[cdi_index] <= write_data;
      end
      // Any write arms the monitor for good
      if (mon_en_we) begin
        mon_en <= 1'b1;
      end
      if (mon_first_we) begin
        mon_first <= write_data;
      end
      if (mon_last_we) begin
        mon_last <= write_data;
      end
    end
  end

  // --------------------
  // Read mux
  // --------------------
  assign ready = cs;

  always_comb begin
    read_data = '0;
    if (cs && !we) begin
      case (address)
        tk1_pkg::ADDR_NAME0:            read_data = tk1_pkg::TK1_NAME0;
        tk1_pkg::ADDR_NAME1:            read_data = tk1_pkg::TK1_NAME1;
        tk1_pkg::ADDR_VERSION:          read_data = tk1_pkg::TK1_VERSION;
        tk1_pkg::ADDR_SYSTEM_MODE_CTRL: read_data = {32{system_mode}};
        tk1_pkg::ADDR_APP_START:        read_data = app_start;
        tk1_pkg::ADDR_APP_SIZE:         read_data = app_size;
        tk1_pkg::ADDR_BLAKE2S:          read_data = blake2s_addr;
        tk1_pkg::ADDR_SYSCALL:          read_data = syscall_addr;
        tk1_pkg::ADDR_CPU_MON_CTRL:     read_data = {31'b0, mon_en};
        tk1_pkg::ADDR_CPU_MON_FIRST:    read_data = mon_first;
        tk1_pkg::ADDR_CPU_MON_LAST:     read_data = mon_last;
        default: begin
          if (cdi_hit) begin
            read_data = cdi_mem[cdi_index];
          end
        end
      endcase
    end
  end

  // Armed monitor keeps its window
  a_window_frozen : assert property (
    @(posedge clk) disable iff (!reset_n)
    mon_en |=> mon_en && $stable(mon_first) && $stable(mon_last)
  );

endmodule

`default_nettype wire

// File: hdl/tk1_mode_ctrl.sv
// tk1 privilege mode controller
// Tracks firmware or application mode and ROM execute permission
// from the address of each instruction fetch

`default_nettype none

module tk1_mode_ctrl (
  input  logic           clk,
  input  logic           reset_n,

  input  tk1_pkg::word_t cpu_addr,
  input  logic           cpu_instr,
  input  logic           cpu_valid,

  input  tk1_pkg::word_t syscall_addr,
  input  tk1_pkg::word_t blake2s_addr,

  output logic           system_mode,
  output logic           rom_executable,
  output logic           entry_fetch
);

  tk1_pkg::mode_state_t state;
  tk1_pkg::mode_state_t state_next;
  logic                 rom_exec_next;
  logic                 fetch;
  logic                 above_rom;
  logic                 hit_syscall;
  logic                 hit_blake2s;

  assign fetch       = cpu_valid && cpu_instr;
  assign above_rom   = cpu_addr > tk1_pkg::FW_ROM_LAST;
  assign hit_syscall = cpu_addr == syscall_addr;
  assign hit_blake2s = cpu_addr == blake2s_addr;

  assign entry_fetch = fetch && (hit_syscall || hit_blake2s);
  assign system_mode = (state == tk1_pkg::MODE_APP);

  // Leaving ROM always drops privilege even on an entry address
  always_comb begin
    state_next    = state;
    rom_exec_next = rom_executable;
    if (fetch) begin
      if (above_rom) begin
        state_next    = tk1_pkg::MODE_APP;
        rom_exec_next = 1'b0;
      end else if (hit_syscall) begin
        state_next    = tk1_pkg::MODE_FIRMWARE;
        rom_exec_next = 1'b1;
      end else if (hit_blake2s) begin
        rom_exec_next = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state          <= tk1_pkg::MODE_FIRMWARE;
      rom_executable <= 1'b1;
    end else begin
      state          <= state_next;
      rom_executable <= rom_exec_next;
    end
  end

  // Firmware never runs with ROM locked
  a_fw_rom_exec : assert property (
    @(posedge clk) disable iff (!reset_n) !system_mode |-> rom_executable
  );

endmodule

`default_nettype wire

// File: hdl/tk1_exec_monitor.sv
// tk1 security monitor
// Watches every CPU access and raises a sticky trap on illegal
// RAM addresses, firmware RAM execution, protected ROM execution
// and fetches inside the armed execution monitor window

`default_nettype none

module tk1_exec_monitor (
  input  logic           clk,
  input  logic           reset_n,

  input  tk1_pkg::word_t cpu_addr,
  input  logic           cpu_instr,
  input  logic           cpu_valid,

  input  logic           rom_executable,
  input  logic           entry_fetch,

  input  logic           mon_en,
  input  tk1_pkg::word_t mon_first,
  input  tk1_pkg::word_t mon_last,

  output logic           force_trap
);

  logic fetch;
  logic ram_oob;
  logic fw_ram_fetch;
  logic rom_fetch_denied;
  logic window_fetch;
  logic trap_set;

  assign fetch = cpu_valid && cpu_instr;

  // RAM region beyond the physical size, checked for any access
  assign ram_oob = cpu_valid && (cpu_addr[31:30] == 2'b01) && (|cpu_addr[29:17]);

  assign fw_ram_fetch = fetch &&
                        (cpu_addr >= tk1_pkg::FW_RAM_FIRST) &&
                        (cpu_addr <= tk1_pkg::FW_RAM_LAST);

  // Entry points are the only way back into a locked ROM
  assign rom_fetch_denied = fetch && !rom_executable && !entry_fetch &&
                            (cpu_addr <= tk1_pkg::FW_ROM_LAST);

  // Data-only area set up by firmware
  assign window_fetch = fetch && mon_en &&
                        (cpu_addr >= mon_first) &&
                        (cpu_addr <= mon_last);

  assign trap_set = ram_oob || fw_ram_fetch || rom_fetch_denied || window_fetch;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (trap_set) begin
      force_trap <= 1'b1;
    end
  end

  // Only reset releases the CPU from a trap
  a_trap_sticky : assert property (
    @(posedge clk) disable iff (!reset_n) force_trap |=> force_trap
  );

endmodule

`default_nettype wire

// File: hdl/tk1_top.sv
// tk1 security and control core
// Joins the register file, the privilege mode controller and
// the security monitor behind one bus port and one CPU port

`default_nettype none

module tk1_top (
  input  logic              clk,
  input  logic              reset_n,

  // Register bus
  input  logic              cs,
  input  logic              we,
  input  tk1_pkg::reg_addr_t address,
  input  tk1_pkg::word_t    write_data,
  output tk1_pkg::word_t    read_data,
  output logic              ready,

  // CPU memory interface
  input  tk1_pkg::word_t    cpu_addr,
  input  logic              cpu_instr,
  input  logic              cpu_valid,

  output logic              system_mode,
  output logic              force_trap
);

  // Entry points and monitor window from the register file
  tk1_pkg::word_t syscall_addr;
  tk1_pkg::word_t blake2s_addr;
  tk1_pkg::word_t mon_first;
  tk1_pkg::word_t mon_last;
  logic           mon_en;

  // Fetch qualifiers from the mode controller
  logic           rom_executable;
  logic           entry_fetch;

  tk1_reg_file u_reg_file (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .ready        (ready),
    .system_mode  (system_mode),
    .syscall_addr (syscall_addr),
    .blake2s_addr (blake2s_addr),
    .mon_first    (mon_first),
    .mon_last     (mon_last),
    .mon_en       (mon_en)
  );

  tk1_mode_ctrl u_mode_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_addr       (cpu_addr),
    .cpu_instr      (cpu_instr),
    .cpu_valid      (cpu_valid),
    .syscall_addr   (syscall_addr),
    .blake2s_addr   (blake2s_addr),
    .system_mode    (system_mode),
    .rom_executable (rom_executable),
    .entry_fetch    (entry_fetch)
  );

  tk1_exec_monitor u_exec_monitor (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_addr       (cpu_addr),
    .cpu_instr      (cpu_instr),
    .cpu_valid      (cpu_valid),
    .rom_executable (rom_executable),
    .entry_fetch    (entry_fetch),
    .mon_en         (mon_en),
    .mon_first      (mon_first),
    .mon_last       (mon_last),
    .force_trap     (force_trap)
  );

endmodule

`default_nettype wire

// File: verification/tk1_tb_model.svh
// tk1 reference model
// Expected register contents, privilege state and trap flag,
// plus the compare task shared by all checks

`ifndef TK1_TB_MODEL_SVH
`define TK1_TB_MODEL_SVH

// Stored registers and CDI words by bus address
tk1_pkg::word_t ref_mem [256];
bit             ref_app;
bit             ref_rom_exec;
bit             ref_trap;
bit             ref_mon_en;
int             error_count = 0;
int             check_count = 0;

task automatic reset_model();
  foreach (ref_mem[i]) begin
    ref_mem[i] = '0;
  end
  ref_mem[tk1_pkg::ADDR_BLAKE2S] = tk1_pkg::ILLEGAL_ADDR;
  ref_mem[tk1_pkg::ADDR_SYSCALL] = tk1_pkg::ILLEGAL_ADDR;
  ref_app      = 1'b0;
  ref_rom_exec = 1'b1;
  ref_trap     = 1'b0;
  ref_mon_en   = 1'b0;
endtask

function automatic tk1_pkg::word_t expected_read(input tk1_pkg::reg_addr_t addr);
  case (addr)
    tk1_pkg::ADDR_NAME0:            return tk1_pkg::TK1_NAME0;
    tk1_pkg::ADDR_NAME1:            return tk1_pkg::TK1_NAME1;
    tk1_pkg::ADDR_VERSION:          return tk1_pkg::TK1_VERSION;
    tk1_pkg::ADDR_SYSTEM_MODE_CTRL: return {32{ref_app}};
    tk1_pkg::ADDR_CPU_MON_CTRL:     return {31'b0, ref_mon_en};
    default:                        return ref_mem[addr];
  endcase
endfunction

// True when one CPU access breaks a security rule
function automatic bit access_traps(input tk1_pkg::word_t addr, input bit instr);
  bit entry;
  entry = (addr == ref_mem[tk1_pkg::ADDR_SYSCALL]) ||
          (addr == ref_mem[tk1_pkg::ADDR_BLAKE2S]);
  if ((addr[31:30] == 2'b01) && (|addr[29:17])) begin
    return 1'b1;
  end
  if (!instr) begin
    return 1'b0;
  end
  if ((addr >= tk1_pkg::FW_RAM_FIRST) && (addr <= tk1_pkg::FW_RAM_LAST)) begin
    return 1'b1;
  end
  if ((addr <= tk1_pkg::FW_ROM_LAST) && !ref_rom_exec && !entry) begin
    return 1'b1;
  end
  return ref_mon_en && (addr >= ref_mem[tk1_pkg::ADDR_CPU_MON_FIRST]) &&
         (addr <= ref_mem[tk1_pkg::ADDR_CPU_MON_LAST]);
endfunction

// Advance the model by one clock using the inputs of this cycle
task automatic model_cycle();
  bit fw;
  fw = !ref_app;
  if (cpu_valid) begin
    ref_trap = ref_trap | access_traps(cpu_addr, cpu_instr);
    if (cpu_instr) begin
      if (cpu_addr > tk1_pkg::FW_ROM_LAST) begin
        ref_app      = 1'b1;
        ref_rom_exec = 1'b0;
      end else if (cpu_addr == ref_mem[tk1_pkg::ADDR_SYSCALL]) begin
        ref_app      = 1'b0;
        ref_rom_exec = 1'b1;
      end else if (cpu_addr == ref_mem[tk1_pkg::ADDR_BLAKE2S]) begin
        ref_rom_exec = 1'b1;
      end
    end
  end
  if (cs && we) begin
    case (address)
      tk1_pkg::ADDR_APP_START, tk1_pkg::ADDR_APP_SIZE,
      tk1_pkg::ADDR_BLAKE2S, tk1_pkg::ADDR_SYSCALL: begin
        if (fw) begin
          ref_mem[address] = write_data;
        end
      end
      tk1_pkg::ADDR_CPU_MON_CTRL: ref_mon_en = 1'b1;
      tk1_pkg::ADDR_CPU_MON_FIRST, tk1_pkg::ADDR_CPU_MON_LAST: begin
        if (!ref_mon_en) begin
          ref_mem[address] = write_data;
        end
      end
      default: begin
        if (fw && (address >= tk1_pkg::ADDR_CDI_FIRST) &&
            (address <= tk1_pkg::ADDR_CDI_LAST)) begin
          ref_mem[address] = write_data;
        end
      end
    endcase
  end
endtask

task automatic check_value(input string name, input tk1_pkg::word_t got,
                           input tk1_pkg::word_t exp);
  check_count++;
  if (got !== exp) begin
    $display("CHECK FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    error_count++;
  end
endtask

`endif

// File: verification/tk1_tb.sv
// tk1 core testbench
// Drives bus and CPU sequences into the DUT and compares every
// cycle against the reference model

`default_nettype none

module tk1_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 6;
  localparam int MAX_TEST_OPS = 40;
  localparam int TIMEOUT_NS   =
    NUM_TESTS * (2 * RESET_CYCLES + MAX_TEST_OPS) * CLK_PERIOD + 2000;

  logic               clk;
  logic               reset_n;
  logic               cs;
  logic               we;
  tk1_pkg::reg_addr_t address;
  tk1_pkg::word_t     write_data;
  tk1_pkg::word_t     read_data;
  logic               ready;
  tk1_pkg::word_t     cpu_addr;
  logic               cpu_instr;
  logic               cpu_valid;
  logic               system_mode;
  logic               force_trap;

  integer             seed = 28536;
  int                 test_errors = 0;
  tk1_pkg::word_t     base;
  tk1_pkg::reg_addr_t sel;

  `include "tk1_tb_model.svh"

  tk1_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog timeout, the test sequence did not complete");
    $display("Regression failed");
    $finish;
  end

  // Inputs settle 5 ns after the rising edge, so the falling edge is safe
  always @(negedge clk) begin
    if (reset_n) begin
      check_value("ready", ready, cs);
      if (cs && !we) begin
        check_value("read_data", read_data, expected_read(address));
      end
      check_value("force_trap", force_trap, ref_trap);
      check_value("system_mode", system_mode, ref_app);
      model_cycle();
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive(input logic c, input logic w, input tk1_pkg::reg_addr_t a,
                       input tk1_pkg::word_t d, input logic v, input logic i,
                       input tk1_pkg::word_t ca);
    @(posedge clk);
    #5;
    cs         = c;
    we         = w;
    address    = a;
    write_data = d;
    cpu_valid  = v;
    cpu_instr  = i;
    cpu_addr   = ca;
  endtask

  task automatic bus_write(input tk1_pkg::reg_addr_t a, input tk1_pkg::word_t d);
    drive(1'b1, 1'b1, a, d, 1'b0, 1'b0, '0);
  endtask

  task automatic bus_read(input tk1_pkg::reg_addr_t a);
    drive(1'b1, 1'b0, a, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic cpu_access(input tk1_pkg::word_t ca, input logic i);
    drive(1'b0, 1'b0, '0, '0, 1'b1, i, ca);
  endtask

  task automatic apply_reset();
    drive(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    reset_n = 1'b0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    reset_n = 1'b1;
  endtask

  task automatic finish_test(input string name);
    drive(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    @(negedge clk);
    #1;
    $display("Test %-12s done, %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    cpu_addr   = '0;
    cpu_instr  = 1'b0;
    cpu_valid  = 1'b0;
    reset_model();

    apply_reset();
    bus_read(tk1_pkg::ADDR_NAME0);
    bus_read(tk1_pkg::ADDR_NAME1);
    bus_read(tk1_pkg::ADDR_VERSION);
    bus_read(8'h05);
    bus_read(8'h3f);
    bus_read(8'hff);
    finish_test("id_reads");

    // Four configuration registers, then the eight CDI words
    apply_reset();
    for (int k = 0; k < 12; k++) begin
      case (k)
        0: sel = tk1_pkg::ADDR_APP_START;
        1: sel = tk1_pkg::ADDR_APP_SIZE;
        2: sel = tk1_pkg::ADDR_BLAKE2S;
        3: sel = tk1_pkg::ADDR_SYSCALL;
        default: sel = tk1_pkg::ADDR_CDI_FIRST + 8'(k - 4);
      endcase
      bus_write(sel, $random(seed));
      bus_read(sel);
    end
    finish_test("fw_writes");

    apply_reset();
    bus_write(tk1_pkg::ADDR_SYSCALL, 32'h0000_0100);
    bus_write(tk1_pkg::ADDR_APP_START, 32'h4000_0000);
    cpu_access(32'h4000_0000, 1'b1);
    bus_read(tk1_pkg::ADDR_SYSTEM_MODE_CTRL);
    bus_write(tk1_pkg::ADDR_APP_START, $random(seed));
    bus_write(tk1_pkg::ADDR_APP_SIZE, $random(seed));
    bus_write(tk1_pkg::ADDR_SYSCALL, $random(seed));
    bus_write(tk1_pkg::ADDR_CDI_FIRST + 8'd3, $random(seed));
    bus_read(tk1_pkg::ADDR_APP_START);
    bus_read(tk1_pkg::ADDR_APP_SIZE);
    bus_read(tk1_pkg::ADDR_SYSCALL);
    bus_read(tk1_pkg::ADDR_CDI_FIRST + 8'd3);
    cpu_access(32'h0000_0100, 1'b1);
    bus_read(tk1_pkg::ADDR_SYSTEM_MODE_CTRL);
    finish_test("app_mode");

    apply_reset();
    cpu_access(tk1_pkg::FW_RAM_FIRST + 32'h40, 1'b1);
    cpu_access(32'h0000_0010, 1'b1);
    bus_read(tk1_pkg::ADDR_NAME0);
    apply_reset();
    cpu_access(32'h4002_0000, 1'b0);
    cpu_access(32'h0000_0020, 1'b1);
    finish_test("trap_sticky");

    apply_reset();
    bus_write(tk1_pkg::ADDR_SYSCALL, 32'h0000_0200);
    bus_write(tk1_pkg::ADDR_BLAKE2S, 32'h0000_0300);
    cpu_access(32'h4000_0000, 1'b1);
    cpu_access(32'h0000_0300, 1'b1);
    cpu_access(32'h0000_0304, 1'b1);
    cpu_access(32'h4000_0004, 1'b1);
    cpu_access(32'h0000_0200, 1'b1);
    cpu_access(32'h4000_0008, 1'b1);
    cpu_access(32'h0000_0100, 1'b1);
    finish_test("rom_in_app");

    // Window stays inside the RAM region below bit 17
    apply_reset();
    base = 32'h4000_0000 + ($random(seed) & 32'h0000_fff0);
    bus_write(tk1_pkg::ADDR_CPU_MON_FIRST, base);
    bus_write(tk1_pkg::ADDR_CPU_MON_LAST, base + 32'h100);
    bus_write(tk1_pkg::ADDR_CPU_MON_CTRL, 32'h1);
    bus_write(tk1_pkg::ADDR_CPU_MON_FIRST, $random(seed));
    bus_write(tk1_pkg::ADDR_CPU_MON_LAST, $random(seed));
    bus_read(tk1_pkg::ADDR_CPU_MON_CTRL);
    bus_read(tk1_pkg::ADDR_CPU_MON_FIRST);
    bus_read(tk1_pkg::ADDR_CPU_MON_LAST);
    cpu_access(base + 32'h104, 1'b1);
    cpu_access(base - 32'h4, 1'b1);
    cpu_access(base + 32'h8, 1'b1);
    finish_test("monitor");

    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verification
hdl/tk1_pkg.sv
hdl/tk1_reg_file.sv
hdl/tk1_mode_ctrl.sv
hdl/tk1_exec_monitor.sv
hdl/tk1_top.sv
verification/tk1_tb.sv

// File: Bender.yml
package:
  name: tk1_core

sources:
  - hdl/tk1_pkg.sv
  - hdl/tk1_reg_file.sv
  - hdl/tk1_mode_ctrl.sv
  - hdl/tk1_exec_monitor.sv
  - hdl/tk1_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tk1_tb.sv
